// File: common/l2_cache_macros.svh
// Sizing macros for the L2 cache pipeline, included by the package, the RTL and the testbench
`ifndef L2_CACHE_MACROS_SVH
`define L2_CACHE_MACROS_SVH

////////////////////////////////
// Line geometry
////////////////////////////////

`define L2_LINE_BYTES 16
`define L2_LINE_WIDTH (`L2_LINE_BYTES * 8)

////////////////////////////////
// Address split
////////////////////////////////

`define L2_ADDR_WIDTH 26        // Line address without the byte offset
`define L2_NUM_WAYS 4
`define L2_WAY_WIDTH 2
`define L2_SET_INDEX_WIDTH 4    // 16 sets
`define L2_TAG_WIDTH (`L2_ADDR_WIDTH - `L2_SET_INDEX_WIDTH)

////////////////////////////////
// Requester identity
////////////////////////////////

`define L2_UNIT_WIDTH 2
`define L2_STRAND_WIDTH 2

`endif

// File: common/l2_cache_pkg.sv
// Shared types of the L2 cache pipeline, referenced by scoped name from the RTL and the testbench
`default_nettype none

`include "l2_cache_macros.svh"

package l2_cache_pkg;

	typedef enum logic
	{
		op_load,
		op_store
	} l2_op_t;

	typedef enum logic [1:0]
	{
		st_hit,
		st_miss,
		st_filled
	} l2_status_t;

	// Requester sees the raw line address, the tag stage splits it
	typedef union packed
	{
		logic [`L2_ADDR_WIDTH - 1:0] line;
		struct packed
		{
			logic [`L2_TAG_WIDTH - 1:0] tag;
			logic [`L2_SET_INDEX_WIDTH - 1:0] set;
		} fields;
	} l2_addr_t;

	////////////////////////////////
	// Pipeline stage contents
	////////////////////////////////

	typedef struct packed
	{
		logic valid;
		logic [`L2_UNIT_WIDTH - 1:0] unit;
		logic [`L2_STRAND_WIDTH - 1:0] strand;
		l2_op_t op;
		l2_addr_t address;
		logic [`L2_LINE_WIDTH - 1:0] data;
		logic [`L2_LINE_BYTES - 1:0] mask;   // One bit per byte
		logic has_sm_data;
		logic [`L2_LINE_WIDTH - 1:0] sm_data;   // Fill line from system memory
	} l2_request_t;

	typedef struct packed
	{
		l2_request_t request;
		logic cache_hit;
		logic [`L2_WAY_WIDTH - 1:0] hit_way;
		logic [`L2_WAY_WIDTH - 1:0] replace_way;
	} l2_tag_stage_t;

	typedef struct packed
	{
		l2_tag_stage_t tag_stage;
		logic [`L2_SET_INDEX_WIDTH + `L2_WAY_WIDTH - 1:0] cache_mem_addr;
		logic [`L2_LINE_WIDTH - 1:0] cache_mem_result;
	} l2_read_stage_t;

	typedef struct packed
	{
		logic valid;
		logic [`L2_UNIT_WIDTH - 1:0] unit;
		logic [`L2_STRAND_WIDTH - 1:0] strand;
		l2_op_t op;
		l2_addr_t address;
		logic cache_hit;
		logic has_sm_data;
		logic [`L2_LINE_WIDTH - 1:0] data;
	} l2_write_stage_t;

	typedef struct packed
	{
		logic valid;
		logic [`L2_UNIT_WIDTH - 1:0] unit;
		logic [`L2_STRAND_WIDTH - 1:0] strand;
		l2_op_t op;
		l2_addr_t address;
		l2_status_t status;
		logic [`L2_LINE_WIDTH - 1:0] data;
	} l2_response_t;

	// Data array write port
	typedef struct packed
	{
		logic enable;
		logic [`L2_SET_INDEX_WIDTH + `L2_WAY_WIDTH - 1:0] addr;
		logic [`L2_LINE_WIDTH - 1:0] data;
	} l2_update_t;

endpackage

`default_nettype wire

// File: l2_cache/l2_cache_tag.sv
// First L2 pipeline stage that looks up the tags and picks the replacement way, used inside l2_cache
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_tag (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_request_t request,
	output l2_cache_pkg::l2_tag_stage_t tag_stage
);

	localparam int num_sets = 1 << `L2_SET_INDEX_WIDTH;

	////////////////////////////////
	// Tag, valid and pointer state
	////////////////////////////////

	logic [`L2_TAG_WIDTH - 1:0] tag_mem [num_sets][`L2_NUM_WAYS];
	logic [num_sets - 1:0][`L2_NUM_WAYS - 1:0] valid_bits;
	logic [num_sets - 1:0][`L2_WAY_WIDTH - 1:0] rr_ptr;   // Next victim per set

	logic [`L2_TAG_WIDTH - 1:0] req_tag;
	logic [`L2_SET_INDEX_WIDTH - 1:0] req_set;
	logic cache_hit;
	logic [`L2_WAY_WIDTH - 1:0] hit_way;
	logic [`L2_WAY_WIDTH - 1:0] replace_way;
	logic [`L2_WAY_WIDTH - 1:0] install_way;
	logic fill;

	assign req_tag = request.address.fields.tag;
	assign req_set = request.address.fields.set;

	// Compare every valid way of the set
	always_comb
	begin
		cache_hit = 1'b0;
		hit_way = '0;
		for (int way = 0; way < `L2_NUM_WAYS; way++)
		begin
			if (valid_bits[req_set][way] && tag_mem[req_set][way] == req_tag)
			begin
				cache_hit = 1'b1;
				hit_way = `L2_WAY_WIDTH'(way);
			end
		end
	end

	assign replace_way = rr_ptr[req_set];
	assign install_way = cache_hit ? hit_way : replace_way;

	// Only fill requests touch the tags, a plain miss changes nothing
	assign fill = request.valid && request.has_sm_data && !stall;

	always_ff @(posedge clk)
	begin
		if (fill)
			tag_mem[req_set][install_way] <= req_tag;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			valid_bits <= '0;
			rr_ptr <= '0;
		end
		else if (fill)
		begin
			valid_bits[req_set][install_way] <= 1'b1;
			if (!cache_hit)
				rr_ptr[req_set] <= rr_ptr[req_set] + 1'b1;   // Refill of a hit way keeps the pointer
		end
	end

	////////////////////////////////
	// Stage register
	////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
			tag_stage.request.valid <= 1'b0;
		else if (!stall)
		begin
			tag_stage.request <= request;
			tag_stage.cache_hit <= cache_hit;
			tag_stage.hit_way <= hit_way;
			tag_stage.replace_way <= replace_way;
		end
	end

endmodule

`default_nettype wire

// File: l2_cache/l2_cache_read.sv
// Second L2 pipeline stage that holds the data array and reads the selected line, used inside l2_cache
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_read (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_tag_stage_t tag_stage,
	input l2_cache_pkg::l2_update_t update,
	output l2_cache_pkg::l2_read_stage_t read_stage
);

	localparam int num_lines = 1 << (`L2_SET_INDEX_WIDTH + `L2_WAY_WIDTH);

	logic [`L2_LINE_WIDTH - 1:0] data_mem [num_lines];

	logic [`L2_WAY_WIDTH - 1:0] read_way;
	logic [`L2_SET_INDEX_WIDTH + `L2_WAY_WIDTH - 1:0] read_addr;
	logic [`L2_LINE_WIDTH - 1:0] old_line;

	////////////////////////////////
	// Read port
	////////////////////////////////

	// Hit way when present, else the line about to be replaced
	assign read_way = tag_stage.cache_hit ? tag_stage.hit_way : tag_stage.replace_way;
	assign read_addr = {tag_stage.request.address.fields.set, read_way};

	// A fill line takes the place of the stale array contents
	always_comb
	begin
		if (tag_stage.request.has_sm_data)
			old_line = tag_stage.request.sm_data;
		else
			old_line = data_mem[read_addr];
	end

	////////////////////////////////
	// Write port
	////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (update.enable && !stall)
			data_mem[update.addr] <= update.data;
	end

	// Stage register
	always_ff @(posedge clk)
	begin
		if (rst)
			read_stage.tag_stage.request.valid <= 1'b0;
		else if (!stall)
		begin
			read_stage.tag_stage <= tag_stage;
			read_stage.cache_mem_addr <= read_addr;
			read_stage.cache_mem_result <= old_line;   // Sees the array before this edge's write
		end
	end

endmodule

`default_nettype wire

// File: l2_cache/l2_cache_write.sv
// Third L2 pipeline stage that merges store bytes and issues the data array write, used inside l2_cache
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_write (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_read_stage_t read_stage,
	output l2_cache_pkg::l2_update_t update,
	output l2_cache_pkg::l2_write_stage_t write_stage
);

	l2_cache_pkg::l2_request_t req;
	logic [`L2_LINE_WIDTH - 1:0] merged_line;
	logic store_write;
	logic fill_write;

	assign req = read_stage.tag_stage.request;

	// Byte lanes with a set mask bit come from the store
	always_comb
	begin
		for (int b = 0; b < `L2_LINE_BYTES; b++)
		begin
			if (req.mask[b])
				merged_line[b * 8 +: 8] = req.data[b * 8 +: 8];
			else
				merged_line[b * 8 +: 8] = read_stage.cache_mem_result[b * 8 +: 8];
		end
	end

	assign store_write = req.valid && req.op == l2_cache_pkg::op_store
		&& (read_stage.tag_stage.cache_hit || req.has_sm_data);
	assign fill_write = req.valid && req.has_sm_data;

	////////////////////////////////
	// Array update
	////////////////////////////////

	always_comb
	begin
		update.addr = read_stage.cache_mem_addr;
		if (store_write)
		begin
			update.enable = 1'b1;
			update.data = merged_line;
		end
		else if (fill_write)
		begin
			update.enable = 1'b1;   // Load fill installs the line
			update.data = req.sm_data;
		end
		else
		begin
			update.enable = 1'b0;
			update.data = '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			write_stage.valid <= 1'b0;
		else if (!stall)
		begin
			write_stage.valid <= req.valid;
			write_stage.unit <= req.unit;
			write_stage.strand <= req.strand;
			write_stage.op <= req.op;
			write_stage.address <= req.address;
			write_stage.cache_hit <= read_stage.tag_stage.cache_hit;
			write_stage.has_sm_data <= req.has_sm_data;
			write_stage.data <= store_write ? merged_line : read_stage.cache_mem_result;
		end
	end

endmodule

`default_nettype wire

// File: l2_cache/l2_cache_response.sv
// Last L2 pipeline stage that forms and holds the response, used inside l2_cache
`timescale 1ns/1ns
`default_nettype none

module l2_cache_response (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_write_stage_t write_stage,
	output l2_cache_pkg::l2_response_t response
);

	l2_cache_pkg::l2_status_t status;

	// Fill wins over hit since a refill may also hit
	always_comb
	begin
		if (write_stage.has_sm_data)
			status = l2_cache_pkg::st_filled;
		else if (write_stage.cache_hit)
			status = l2_cache_pkg::st_hit;
		else
			status = l2_cache_pkg::st_miss;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			response.valid <= 1'b0;
		else if (!stall)
		begin
			response.valid <= write_stage.valid;
			response.unit <= write_stage.unit;
			response.strand <= write_stage.strand;
			response.op <= write_stage.op;
			response.address <= write_stage.address;
			response.status <= status;
			if (status == l2_cache_pkg::st_miss)
				response.data <= '0;   // No line to report
			else
				response.data <= write_stage.data;
		end
	end

endmodule

`default_nettype wire

// File: l2_cache/l2_cache.sv
// Top level of the shared L2 cache that chains the four pipeline stages
`timescale 1ns/1ns
`default_nettype none

module l2_cache (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_request_t request,
	output l2_cache_pkg::l2_response_t response
);

	l2_cache_pkg::l2_tag_stage_t tag_stage;
	l2_cache_pkg::l2_read_stage_t read_stage;
	l2_cache_pkg::l2_write_stage_t write_stage;
	l2_cache_pkg::l2_update_t update;   // Write stage back to the data array

	l2_cache_tag tag (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.request(request),
		.tag_stage(tag_stage)
	);

	l2_cache_read read (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.tag_stage(tag_stage),
		.update(update),
		.read_stage(read_stage)
	);

	l2_cache_write write (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.read_stage(read_stage),
		.update(update),
		.write_stage(write_stage)
	);

	l2_cache_response resp (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.write_stage(write_stage),
		.response(response)
	);

endmodule

`default_nettype wire

// File: sim/l2_cache_checker.sv
// Concurrent assertions on the L2 cache pipeline, attached to every l2_cache by the bind at the end
`timescale 1ns/1ns
`default_nettype none

module l2_cache_checker (
	input logic clk,
	input logic rst,
	input logic stall,
	input l2_cache_pkg::l2_read_stage_t read_stage,
	input l2_cache_pkg::l2_update_t update,
	input l2_cache_pkg::l2_response_t response
);

	int assert_fails = 0;   // Read by the testbench at the end

	// Pipeline comes up empty
	reset_empty: assert property (@(posedge clk) rst |=> !response.valid && !update.enable)
	else
	begin
		assert_fails++;
		$error("Valid output in the cycle after reset");
	end

	// Only hits and fills may write the data array
	no_miss_write: assert property (@(posedge clk) disable iff (rst)
		update.enable |-> read_stage.tag_stage.cache_hit || read_stage.tag_stage.request.has_sm_data)
	else
	begin
		assert_fails++;
		$error("Data array written for a miss");
	end

	stall_hold: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable(response.valid) && (!response.valid || $stable(response)))
	else
	begin
		assert_fails++;
		$error("Response changed while stalled");
	end

endmodule

bind l2_cache l2_cache_checker u_checker (
	.clk(clk),
	.rst(rst),
	.stall(stall),
	.read_stage(read_stage),
	.update(update),
	.response(response)
);

`default_nettype wire

// File: sim/l2_cache_tb.sv
// Self-checking testbench of the L2 cache pipeline, compiled from build.f and run as the top
`timescale 1ns/1ns
`default_nettype none

`include "l2_cache_macros.svh"

module l2_cache_tb;

	localparam int drive_delay = 2;
	localparam int wait_limit = 200;   // Cycles before a drain gives up

	logic clk;
	logic rst;
	logic stall;
	l2_cache_pkg::l2_request_t request;
	l2_cache_pkg::l2_response_t response;

	integer seed = 32'h60e8_66e2;
	int errors = 0;
	int issued = 0;
	int checked = 0;

	////////////////////////////////
	// Reference model state
	////////////////////////////////

	logic [`L2_LINE_WIDTH - 1:0] model_mem [logic [`L2_ADDR_WIDTH - 1:0]];
	logic [`L2_ADDR_WIDTH - 1:0] set_lines [1 << `L2_SET_INDEX_WIDTH][$];   // Oldest fill first
	l2_cache_pkg::l2_response_t expected_q [$];

	l2_cache i_dut (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.request(request),
		.response(response)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	function automatic logic [`L2_ADDR_WIDTH - 1:0] line_of(input int tag, input int set_index);
		return {`L2_TAG_WIDTH'(tag), `L2_SET_INDEX_WIDTH'(set_index)};
	endfunction

	function automatic logic [`L2_LINE_WIDTH - 1:0] random_line();
		logic [`L2_LINE_WIDTH - 1:0] line;
		for (int i = 0; i < `L2_LINE_WIDTH / 32; i++)
			line[i * 32 +: 32] = $random(seed);
		return line;
	endfunction

	function automatic logic [`L2_LINE_WIDTH - 1:0] merge_bytes(
		input logic [`L2_LINE_WIDTH - 1:0] old_line,
		input logic [`L2_LINE_WIDTH - 1:0] new_line,
		input logic [`L2_LINE_BYTES - 1:0] mask
	);
		logic [`L2_LINE_WIDTH - 1:0] line;
		line = old_line;
		for (int b = 0; b < `L2_LINE_BYTES; b++)
			if (mask[b])
				line[b * 8 +: 8] = new_line[b * 8 +: 8];
		return line;
	endfunction

	function automatic l2_cache_pkg::l2_request_t make_request(input l2_cache_pkg::l2_op_t op,
		input logic [`L2_ADDR_WIDTH - 1:0] line, input bit fill);
		l2_cache_pkg::l2_request_t req;
		req.valid = 1'b1;
		req.unit = `L2_UNIT_WIDTH'($random(seed));
		req.strand = `L2_STRAND_WIDTH'($random(seed));
		req.op = op;
		req.address.line = line;
		req.data = random_line();
		req.mask = `L2_LINE_BYTES'($random(seed));
		req.has_sm_data = fill;
		req.sm_data = fill ? random_line() : '0;
		return req;
	endfunction

	// Expected status and line from the model as it stands before this request
	function automatic l2_cache_pkg::l2_response_t predict_response(
		input l2_cache_pkg::l2_request_t req
	);
		l2_cache_pkg::l2_response_t rsp;
		logic [`L2_LINE_WIDTH - 1:0] base;
		rsp.valid = 1'b1;
		rsp.unit = req.unit;
		rsp.strand = req.strand;
		rsp.op = req.op;
		rsp.address = req.address;
		if (req.has_sm_data)
		begin
			rsp.status = l2_cache_pkg::st_filled;
			base = req.sm_data;
		end
		else if (model_mem.exists(req.address.line))
		begin
			rsp.status = l2_cache_pkg::st_hit;
			base = model_mem[req.address.line];
		end
		else
		begin
			rsp.status = l2_cache_pkg::st_miss;
			base = '0;
		end
		if (req.op == l2_cache_pkg::op_store && rsp.status != l2_cache_pkg::st_miss)
			rsp.data = merge_bytes(base, req.data, req.mask);
		else
			rsp.data = base;
		return rsp;
	endfunction

	task automatic accept_request(input l2_cache_pkg::l2_request_t req);
		l2_cache_pkg::l2_response_t rsp;
		logic [`L2_ADDR_WIDTH - 1:0] victim;
		int set_index;
		rsp = predict_response(req);
		set_index = int'(req.address.line[`L2_SET_INDEX_WIDTH - 1:0]);
		if (req.has_sm_data && !model_mem.exists(req.address.line))
		begin
			set_lines[set_index].push_back(req.address.line);
			if (set_lines[set_index].size() > `L2_NUM_WAYS)
			begin
				victim = set_lines[set_index].pop_front();   // Round-robin victim
				model_mem.delete(victim);
			end
		end
		if (rsp.status != l2_cache_pkg::st_miss)
			model_mem[req.address.line] = rsp.data;
		expected_q.push_back(rsp);
		issued++;
	endtask

	// Holds the request through stall_cycles stalled edges, then lets it in
	task automatic issue_request(input l2_cache_pkg::l2_request_t req, input int stall_cycles);
		request = req;
		for (int i = 0; i < stall_cycles; i++)
		begin
			stall = 1'b1;
			@(posedge clk);
			#drive_delay;
		end
		stall = 1'b0;
		@(posedge clk);
		accept_request(req);
		#drive_delay;
		request.valid = 1'b0;
	endtask

	task automatic wait_responses(input bit random_stall);
		int cycles;
		cycles = 0;
		while (expected_q.size() != 0 && cycles < wait_limit)
		begin
			stall = random_stall && (($random(seed) & 1) != 0);
			@(posedge clk);
			#drive_delay;
			cycles++;
		end
		stall = 1'b0;
		if (expected_q.size() != 0)
		begin
			errors++;
			$display("Timed out at %0t with %0d responses missing", $time, expected_q.size());
			expected_q.delete();
		end
	endtask

	task automatic compare_value(input string name, input logic [`L2_LINE_WIDTH - 1:0] actual,
		input logic [`L2_LINE_WIDTH - 1:0] expected);
		assert (actual === expected)
		else
		begin
			errors++;
			$display("ERROR %0t %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	////////////////////////////////
	// Response comparison
	////////////////////////////////

	initial
	begin
		l2_cache_pkg::l2_response_t head;
		forever
		begin
			@(negedge clk);
			if (!rst && response.valid && !stall)   // Consumed at the coming edge
			begin
				assert (expected_q.size() != 0)
				else
				begin
					errors++;
					$display("Response at %0t arrived with no request outstanding", $time);
				end
				if (expected_q.size() != 0)
				begin
					head = expected_q.pop_front();
					checked++;
					compare_value("response.unit", response.unit, head.unit);
					compare_value("response.strand", response.strand, head.strand);
					compare_value("response.op", response.op, head.op);
					compare_value("response.address", response.address.line, head.address.line);
					compare_value("response.status", response.status, head.status);
					compare_value("response.data", response.data, head.data);
				end
			end
		end
	end

	////////////////////////////////
	// Stimulus
	////////////////////////////////

	initial
	begin
		l2_cache_pkg::l2_request_t req;
		logic [`L2_ADDR_WIDTH - 1:0] line_a;
		logic [`L2_ADDR_WIDTH - 1:0] line_b;
		int r;
		rst = 1'b1;
		stall = 1'b0;
		request = '0;
		repeat (16) @(posedge clk);
		#drive_delay;
		rst = 1'b0;

		// Miss, fill, then hit on one line
		line_a = line_of(17, 3);
		issue_request(make_request(l2_cache_pkg::op_load, line_a, 1'b0), 0);
		wait_responses(1'b0);
		issue_request(make_request(l2_cache_pkg::op_load, line_a, 1'b1), 0);
		wait_responses(1'b0);
		issue_request(make_request(l2_cache_pkg::op_load, line_a, 1'b0), 0);
		wait_responses(1'b0);

		issue_request(make_request(l2_cache_pkg::op_store, line_a, 1'b0), 0);
		wait_responses(1'b0);
		issue_request(make_request(l2_cache_pkg::op_load, line_a, 1'b0), 0);
		wait_responses(1'b0);

		// Store merged over a fill line
		line_b = line_of(18, 5);
		issue_request(make_request(l2_cache_pkg::op_store, line_b, 1'b1), 0);
		wait_responses(1'b0);
		issue_request(make_request(l2_cache_pkg::op_load, line_b, 1'b0), 0);
		wait_responses(1'b0);

		// Five tags into set 9 push out the first
		for (int t = 0; t < 5; t++)
		begin
			issue_request(make_request(l2_cache_pkg::op_load, line_of(32 + t, 9), 1'b1), 0);
			wait_responses(1'b0);
		end
		for (int t = 0; t < 5; t++)
		begin
			issue_request(make_request(l2_cache_pkg::op_load, line_of(32 + t, 9), 1'b0), 0);
			wait_responses(1'b0);
		end

		// Two passes of back-to-back distinct lines under random stall
		for (int pass = 0; pass < 2; pass++)
		begin
			for (int i = 0; i < 32; i++)
			begin
				r = $random(seed);
				req = make_request((r & 1) ? l2_cache_pkg::op_store : l2_cache_pkg::op_load,
					line_of(64 + i, i), (r & 2) != 0);
				issue_request(req, ((r & 12) == 0) ? 1 + ((r >> 4) & 3) : 0);
			end
			wait_responses(1'b1);
		end

		assert (checked == issued)
		else
		begin
			errors++;
			$display("Issued %0d requests but saw %0d responses", issued, checked);
		end

		$display("Responses checked %0d, errors %0d, assertion failures %0d",
			checked, errors, i_dut.u_checker.assert_fails);
		if (errors == 0 && i_dut.u_checker.assert_fails == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+common
common/l2_cache_pkg.sv
l2_cache/l2_cache_tag.sv
l2_cache/l2_cache_read.sv
l2_cache/l2_cache_write.sv
l2_cache/l2_cache_response.sv
l2_cache/l2_cache.sv
sim/l2_cache_checker.sv
sim/l2_cache_tb.sv

// File: Bender.yml
package:
  name: l2_cache

export_include_dirs:
  - common

sources:
  - files:
      - common/l2_cache_pkg.sv
      - l2_cache/l2_cache_tag.sv
      - l2_cache/l2_cache_read.sv
      - l2_cache/l2_cache_write.sv
      - l2_cache/l2_cache_response.sv
      - l2_cache/l2_cache.sv
  - target: simulation
    files:
      - sim/l2_cache_checker.sv
      - sim/l2_cache_tb.sv
